/* verilog/ecc_pkg.sv */
package ecc_pkg;

    localparam int DATA_WIDTH   = 72;
    localparam int PARITY_WIDTH = 8;
    localparam int CODE_WIDTH   = DATA_WIDTH + PARITY_WIDTH;
    localparam int COUNT_WIDTH  = 16;

    typedef logic [DATA_WIDTH-1:0]   data_t;
    typedef logic [PARITY_WIDTH-1:0] parity_t;
    // codeword layout is {data, parity}.
    typedef logic [CODE_WIDTH-1:0]   code_t;
    typedef logic [COUNT_WIDTH-1:0]  count_t;

    // each check bit is the xor of its data bits.
    function automatic parity_t ecc_encode(input data_t d);
        parity_t p;
        p[0] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10] ^ d[11] ^ d[13] ^ d[15] ^
               d[17] ^ d[19] ^ d[21] ^ d[23] ^ d[25] ^ d[26] ^ d[28] ^ d[30] ^ d[32] ^
               d[34] ^ d[36] ^ d[38] ^ d[40] ^ d[42] ^ d[44] ^ d[46] ^ d[48] ^ d[50] ^
               d[52] ^ d[54] ^ d[56] ^ d[57] ^ d[59] ^ d[61] ^ d[63] ^ d[65] ^ d[67] ^
               d[69] ^ d[71];
        p[1] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[10] ^ d[12] ^ d[13] ^ d[16] ^
               d[17] ^ d[20] ^ d[21] ^ d[24] ^ d[25] ^ d[27] ^ d[28] ^ d[31] ^ d[32] ^
               d[35] ^ d[36] ^ d[39] ^ d[40] ^ d[43] ^ d[44] ^ d[47] ^ d[48] ^ d[51] ^
               d[52] ^ d[55] ^ d[56] ^ d[58] ^ d[59] ^ d[62] ^ d[63] ^ d[66] ^ d[67] ^
               d[70] ^ d[71];
        p[2] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[10] ^ d[14] ^ d[15] ^ d[16] ^
               d[17] ^ d[22] ^ d[23] ^ d[24] ^ d[25] ^ d[29] ^ d[30] ^ d[31] ^ d[32] ^
               d[37] ^ d[38] ^ d[39] ^ d[40] ^ d[45] ^ d[46] ^ d[47] ^ d[48] ^ d[53] ^
               d[54] ^ d[55] ^ d[56] ^ d[60] ^ d[61] ^ d[62] ^ d[63] ^ d[68] ^ d[69] ^
               d[70] ^ d[71];
        p[3] = ^{d[71:64], d[56:49], d[40:33], d[25:18], d[10:4]};
        p[4] = ^{d[56:41], d[25:11]};
        p[5] = ^d[56:26];
        p[6] = ^d[71:57];
        // overall bit keeps every data column at odd weight.
        p[7] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7] ^ d[10] ^ d[11] ^ d[12] ^ d[14] ^
               d[17] ^ d[18] ^ d[21] ^ d[23] ^ d[24] ^ d[26] ^ d[27] ^ d[29] ^ d[32] ^
               d[33] ^ d[36] ^ d[38] ^ d[39] ^ d[41] ^ d[44] ^ d[46] ^ d[47] ^ d[50] ^
               d[51] ^ d[53] ^ d[56] ^ d[57] ^ d[58] ^ d[60] ^ d[63] ^ d[64] ^ d[67] ^
               d[69] ^ d[70];
        return p;
    endfunction

endpackage

/* verilog/ecc_word_if.sv */
`timescale 1ns/1ps

// one codeword link with four-phase req/ack.
interface ecc_word_if;
    import ecc_pkg::*;

    logic    req;
    logic    ack;
    data_t   data;
    parity_t parity;

    modport source (
        output req,
        output data,
        output parity,
        input  ack
    );

    modport sink (
        input  req,
        input  data,
        input  parity,
        output ack
    );

endinterface

/* verilog/ecc_72_cal.sv */
`timescale 1ns/1ps

module ecc_72_cal (
    input  ecc_pkg::data_t   data_in,
    input  ecc_pkg::parity_t parity_in,
    input  logic             bypass,
    output ecc_pkg::data_t   data_out,
    output ecc_pkg::parity_t parity_out,
    output ecc_pkg::data_t   mask,
    output logic             sbit_err,
    output logic             dbit_err
);
    import ecc_pkg::*;

    parity_t    syndrome;
    logic [6:0] bit_idx;
    logic       data_hit;
    logic       check_hit;
    logic       multi_err;

    assign parity_out = ecc_encode(data_in);
    assign syndrome   = parity_in ^ parity_out;

    // syndrome to data bit position with one entry per column.
    always_comb begin
        bit_idx   = 7'd0;
        data_hit  = 1'b1;
        check_hit = 1'b0;
        multi_err = 1'b0;
        case (syndrome)
            8'h00: data_hit = 1'b0;
            8'h83: bit_idx = 7'd0;
            8'h85: bit_idx = 7'd1;
            8'h86: bit_idx = 7'd2;
            8'h07: bit_idx = 7'd3;
            8'h89: bit_idx = 7'd4;
            8'h8a: bit_idx = 7'd5;
            8'h0b: bit_idx = 7'd6;
            8'h8c: bit_idx = 7'd7;
            8'h0d: bit_idx = 7'd8;
            8'h0e: bit_idx = 7'd9;
            8'h8f: bit_idx = 7'd10;
            8'h91: bit_idx = 7'd11;
            8'h92: bit_idx = 7'd12;
            8'h13: bit_idx = 7'd13;
            8'h94: bit_idx = 7'd14;
            8'h15: bit_idx = 7'd15;
            8'h16: bit_idx = 7'd16;
            8'h97: bit_idx = 7'd17;
            8'h98: bit_idx = 7'd18;
            8'h19: bit_idx = 7'd19;
            8'h1a: bit_idx = 7'd20;
            8'h9b: bit_idx = 7'd21;
            8'h1c: bit_idx = 7'd22;
            8'h9d: bit_idx = 7'd23;
            8'h9e: bit_idx = 7'd24;
            8'h1f: bit_idx = 7'd25;
            8'ha1: bit_idx = 7'd26;
            8'ha2: bit_idx = 7'd27;
            8'h23: bit_idx = 7'd28;
            8'ha4: bit_idx = 7'd29;
            8'h25: bit_idx = 7'd30;
            8'h26: bit_idx = 7'd31;
            8'ha7: bit_idx = 7'd32;
            8'ha8: bit_idx = 7'd33;
            8'h29: bit_idx = 7'd34;
            8'h2a: bit_idx = 7'd35;
            8'hab: bit_idx = 7'd36;
            8'h2c: bit_idx = 7'd37;
            8'had: bit_idx = 7'd38;
            8'hae: bit_idx = 7'd39;
            8'h2f: bit_idx = 7'd40;
            8'hb0: bit_idx = 7'd41;
            8'h31: bit_idx = 7'd42;
            8'h32: bit_idx = 7'd43;
            8'hb3: bit_idx = 7'd44;
            8'h34: bit_idx = 7'd45;
            8'hb5: bit_idx = 7'd46;
            8'hb6: bit_idx = 7'd47;
            8'h37: bit_idx = 7'd48;
            8'h38: bit_idx = 7'd49;
            8'hb9: bit_idx = 7'd50;
            8'hba: bit_idx = 7'd51;
            8'h3b: bit_idx = 7'd52;
            8'hbc: bit_idx = 7'd53;
            8'h3d: bit_idx = 7'd54;
            8'h3e: bit_idx = 7'd55;
            8'hbf: bit_idx = 7'd56;
            8'hc1: bit_idx = 7'd57;
            8'hc2: bit_idx = 7'd58;
            8'h43: bit_idx = 7'd59;
            8'hc4: bit_idx = 7'd60;
            8'h45: bit_idx = 7'd61;
            8'h46: bit_idx = 7'd62;
            8'hc7: bit_idx = 7'd63;
            8'hc8: bit_idx = 7'd64;
            8'h49: bit_idx = 7'd65;
            8'h4a: bit_idx = 7'd66;
            8'hcb: bit_idx = 7'd67;
            8'h4c: bit_idx = 7'd68;
            8'hcd: bit_idx = 7'd69;
            8'hce: bit_idx = 7'd70;
            8'h4f: bit_idx = 7'd71;
            // a flipped check bit leaves the data good.
            8'h01, 8'h02, 8'h04, 8'h08, 8'h10, 8'h20, 8'h40, 8'h80: begin
                data_hit  = 1'b0;
                check_hit = 1'b1;
            end
            default: begin
                data_hit  = 1'b0;
                multi_err = 1'b1;
            end
        endcase
    end

    assign mask     = data_hit ? (data_t'(1) << bit_idx) : '0;
    assign data_out = bypass ? data_in : (data_in ^ mask);
    assign sbit_err = bypass ? 1'b0 : (data_hit | check_hit);
    assign dbit_err = bypass ? 1'b0 : multi_err;

endmodule

/* verilog/ecc_write_port.sv */
`timescale 1ns/1ps

module ecc_write_port (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             in_req,
    output logic             in_ack,
    input  ecc_pkg::data_t   in_data,
    input  ecc_pkg::code_t   in_flip,
    ecc_word_if.source       wr
);
    import ecc_pkg::*;

    typedef enum logic [1:0] {
        W_EMPTY,
        W_LOADED,
        W_REQ,
        W_RELEASE
    } wstate_t;

    wstate_t state;
    code_t   hold_code;
    logic    wr_req_q;
    logic    capture;

    assign capture = in_req && !in_ack && (state == W_EMPTY);

    assign wr.req    = wr_req_q;
    assign wr.data   = hold_code[CODE_WIDTH-1:PARITY_WIDTH];
    assign wr.parity = hold_code[PARITY_WIDTH-1:0];

    // fault pattern models an upset in the stored codeword.
    always_ff @(posedge clk) begin
        if (capture) begin
            hold_code <= {in_data, ecc_encode(in_data)} ^ in_flip;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= W_EMPTY;
            in_ack   <= 1'b0;
            wr_req_q <= 1'b0;
        end else begin
            if (capture) begin
                in_ack <= 1'b1;
            end else if (in_ack && !in_req) begin
                in_ack <= 1'b0;
            end

            case (state)
                W_EMPTY: begin
                    if (capture) begin
                        state <= W_LOADED;
                    end
                end
                W_LOADED: begin
                    wr_req_q <= 1'b1;
                    state    <= W_REQ;
                end
                W_REQ: begin
                    if (wr.ack) begin
                        wr_req_q <= 1'b0;
                        state    <= W_RELEASE;
                    end
                end
                // holder frees once the fifo drops ack.
                W_RELEASE: begin
                    if (!wr.ack) begin
                        state <= W_EMPTY;
                    end
                end
                default: state <= W_EMPTY;
            endcase
        end
    end

endmodule

/* verilog/ecc_word_fifo.sv */
`timescale 1ns/1ps

module ecc_word_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic      clk,
    input  logic      arst_n,
    ecc_word_if.sink  wr,
    ecc_word_if.source rd
);
    import ecc_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    code_t            mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_ack_q;
    logic             rd_req_q;
    logic             full;
    logic             empty;
    logic             push;
    logic             pop;
    code_t            head;

    assign full  = (count == CNT_W'(FIFO_DEPTH));
    assign empty = (count == '0);

    // no ack while full holds the writer off.
    assign push = wr.req && !wr_ack_q && !full;
    assign pop  = rd_req_q && rd.ack;

    assign head      = mem[rd_ptr];
    assign wr.ack    = wr_ack_q;
    assign rd.req    = rd_req_q;
    assign rd.data   = head[CODE_WIDTH-1:PARITY_WIDTH];
    assign rd.parity = head[PARITY_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= {wr.data, wr.parity};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            wr_ack_q <= 1'b0;
            rd_req_q <= 1'b0;
        end else begin
            if (push) begin
                wr_ack_q <= 1'b1;
                wr_ptr   <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end else if (wr_ack_q && !wr.req) begin
                wr_ack_q <= 1'b0;
            end

            // offer the head only once the previous read has fully closed.
            if (pop) begin
                rd_req_q <= 1'b0;
                rd_ptr   <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end else if (!rd_req_q && !rd.ack && !empty) begin
                rd_req_q <= 1'b1;
            end

            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* verilog/ecc_read_port.sv */
`timescale 1ns/1ps

module ecc_read_port (
    input  logic            clk,
    input  logic            arst_n,
    ecc_word_if.sink        rd,
    input  logic            bypass,
    output logic            out_req,
    input  logic            out_ack,
    output ecc_pkg::data_t  out_data,
    output logic            out_sbit_err,
    output logic            out_dbit_err,
    output ecc_pkg::count_t corr_count,
    output ecc_pkg::count_t uncorr_count
);
    import ecc_pkg::*;

    data_t   in_data_q;
    parity_t in_parity_q;
    logic    in_full;
    logic    rd_ack_q;
    data_t   fix_data;
    logic    fix_sbit;
    logic    fix_dbit;
    logic    take;
    logic    move;

    assign rd.ack = rd_ack_q;
    assign take   = rd.req && !rd_ack_q && !in_full;
    // output stage is free only after the last four-phase cycle closed.
    assign move   = in_full && !out_req && !out_ack;

    ecc_72_cal ecc_72_cal_inst (
        .data_in    (in_data_q),
        .parity_in  (in_parity_q),
        .bypass     (bypass),
        .data_out   (fix_data),
        .parity_out (),
        .mask       (),
        .sbit_err   (fix_sbit),
        .dbit_err   (fix_dbit)
    );

    always_ff @(posedge clk) begin
        if (take) begin
            in_data_q   <= rd.data;
            in_parity_q <= rd.parity;
        end
        if (move) begin
            out_data <= fix_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_full      <= 1'b0;
            rd_ack_q     <= 1'b0;
            out_req      <= 1'b0;
            out_sbit_err <= 1'b0;
            out_dbit_err <= 1'b0;
            corr_count   <= '0;
            uncorr_count <= '0;
        end else begin
            if (take) begin
                in_full  <= 1'b1;
                rd_ack_q <= 1'b1;
            end else begin
                if (rd_ack_q && !rd.req) begin
                    rd_ack_q <= 1'b0;
                end
                if (move) begin
                    in_full <= 1'b0;
                end
            end

            if (move) begin
                out_req      <= 1'b1;
                out_sbit_err <= fix_sbit;
                out_dbit_err <= fix_dbit;
            end else if (out_req && out_ack) begin
                out_req <= 1'b0;
            end

            // counters stick at all ones.
            if (move && fix_sbit && (corr_count != '1)) begin
                corr_count <= corr_count + 1'b1;
            end
            if (move && fix_dbit && (uncorr_count != '1)) begin
                uncorr_count <= uncorr_count + 1'b1;
            end
        end
    end

endmodule

/* verilog/ecc_mem_top.sv */
`timescale 1ns/1ps

module ecc_mem_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            bypass,
    input  logic            in_req,
    output logic            in_ack,
    input  ecc_pkg::data_t  in_data,
    input  ecc_pkg::code_t  in_flip,
    output logic            out_req,
    input  logic            out_ack,
    output ecc_pkg::data_t  out_data,
    output logic            out_sbit_err,
    output logic            out_dbit_err,
    output ecc_pkg::count_t corr_count,
    output ecc_pkg::count_t uncorr_count
);

    ecc_word_if wr_link ();
    ecc_word_if rd_link ();

    ecc_write_port ecc_write_port_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .in_req  (in_req),
        .in_ack  (in_ack),
        .in_data (in_data),
        .in_flip (in_flip),
        .wr      (wr_link.source)
    );

    ecc_word_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) ecc_word_fifo_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .wr     (wr_link.sink),
        .rd     (rd_link.source)
    );

    ecc_read_port ecc_read_port_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .rd           (rd_link.sink),
        .bypass       (bypass),
        .out_req      (out_req),
        .out_ack      (out_ack),
        .out_data     (out_data),
        .out_sbit_err (out_sbit_err),
        .out_dbit_err (out_dbit_err),
        .corr_count   (corr_count),
        .uncorr_count (uncorr_count)
    );

endmodule

/* verif/ecc_mem_tb.sv */
`timescale 1ns/1ps

module ecc_mem_tb;
    import ecc_pkg::*;

    logic   clk;
    logic   arst_n;
    logic   bypass;
    logic   in_req;
    logic   in_ack;
    data_t  in_data;
    code_t  in_flip;
    logic   out_req;
    logic   out_ack;
    data_t  out_data;
    logic   out_sbit_err;
    logic   out_dbit_err;
    count_t corr_count;
    count_t uncorr_count;

    logic   rec_bypass [$];
    data_t  rec_data [$];
    code_t  rec_flip [$];
    data_t  rec_exp [$];
    logic   rec_sbit [$];
    logic   rec_dbit [$];
    int     exp_corr = 0;
    int     exp_uncorr = 0;
    int     n_recv = 0;
    logic   loaded = 1'b0;
    integer seed = 26088;

    ecc_mem_top #(
        .FIFO_DEPTH (4)
    ) ecc_mem_top_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .bypass       (bypass),
        .in_req       (in_req),
        .in_ack       (in_ack),
        .in_data      (in_data),
        .in_flip      (in_flip),
        .out_req      (out_req),
        .out_ack      (out_ack),
        .out_data     (out_data),
        .out_sbit_err (out_sbit_err),
        .out_dbit_err (out_dbit_err),
        .corr_count   (corr_count),
        .uncorr_count (uncorr_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input code_t got, input code_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "check failed");
        end
    endtask

    task automatic load_trace();
        int    fd;
        int    n;
        int    b;
        int    s;
        int    db;
        string line;
        data_t d;
        data_t e;
        code_t f;
        fd = $fopen("verif/ecc_mem_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open trace file verif/ecc_mem_trace.txt");
            $display("SIMULATION FAILED");
            $fatal(1, "no trace");
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0) break;
            if (line.len() == 0 || line.getc(0) == "#") continue;
            n = $sscanf(line, "%h %h %h %h %h %h", b, d, f, e, s, db);
            if (n <= 0) continue;
            if (n != 6) begin
                $display("malformed trace line: %s", line);
                $display("SIMULATION FAILED");
                $fatal(1, "bad trace");
            end
            rec_bypass.push_back(b != 0);
            rec_data.push_back(d);
            rec_flip.push_back(f);
            rec_exp.push_back(e);
            rec_sbit.push_back(s != 0);
            rec_dbit.push_back(db != 0);
            // counters only move outside bypass.
            if (b == 0 && s != 0) exp_corr++;
            if (b == 0 && db != 0) exp_uncorr++;
        end
        $fclose(fd);
        if (rec_data.size() == 0) begin
            $display("trace file holds no records");
            $display("SIMULATION FAILED");
            $fatal(1, "empty trace");
        end
    endtask

    task automatic drive_words();
        int i;
        for (i = 0; i < rec_data.size(); i++) begin
            @(negedge clk);
            // mode may only change once every earlier word is out.
            if (bypass != rec_bypass[i]) begin
                while (n_recv != i || out_ack) @(negedge clk);
                bypass = rec_bypass[i];
            end
            in_data = rec_data[i];
            in_flip = rec_flip[i];
            in_req  = 1'b1;
            @(negedge clk);
            while (!in_ack) @(negedge clk);
            in_req = 1'b0;
            while (in_ack) @(negedge clk);
        end
    endtask

    task automatic collect_words();
        int i;
        int delay;
        for (i = 0; i < rec_data.size(); i++) begin
            @(negedge clk);
            while (!out_req) @(negedge clk);
            delay = $unsigned($random(seed)) % 8;
            repeat (delay) @(negedge clk);
            check_value("out_data", code_t'(out_data), code_t'(rec_exp[i]));
            check_value("out_sbit_err", code_t'(out_sbit_err), code_t'(rec_sbit[i]));
            check_value("out_dbit_err", code_t'(out_dbit_err), code_t'(rec_dbit[i]));
            out_ack = 1'b1;
            while (out_req) @(negedge clk);
            out_ack = 1'b0;
            n_recv++;
        end
    endtask

    initial begin
        arst_n  = 1'b0;
        bypass  = 1'b0;
        in_req  = 1'b0;
        in_data = '0;
        in_flip = '0;
        out_ack = 1'b0;
        load_trace();
        loaded = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        fork
            drive_words();
            collect_words();
        join
        @(negedge clk);
        check_value("corr_count", code_t'(corr_count), code_t'(exp_corr));
        check_value("uncorr_count", code_t'(uncorr_count), code_t'(exp_uncorr));
        $display("SIMULATION PASSED");
        $finish;
    end

    // 200 cycles per record.
    initial begin
        wait (loaded);
        repeat (rec_data.size() * 200) @(posedge clk);
        $display("timeout, output stalled after %0d of %0d words", n_recv, rec_data.size());
        $display("SIMULATION FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

/* ecc_mem.f */
verilog/ecc_pkg.sv
verilog/ecc_word_if.sv
verilog/ecc_72_cal.sv
verilog/ecc_write_port.sv
verilog/ecc_word_fifo.sv
verilog/ecc_read_port.sv
verilog/ecc_mem_top.sv
verif/ecc_mem_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       = ecc_mem_tb
FILELIST  = ecc_mem.f
OBJ_DIR   = obj_dir
VFLAGS    = --timing --top-module $(TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) --binary -j 0 $(VFLAGS) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* verif/ecc_mem_trace.txt */
# bypass in_data in_flip exp_data exp_sbit exp_dbit, all fields hex.
# in_flip is {72 data flip bits, 8 check flip bits}.
0 000000000000000000 00000000000000000000 000000000000000000 0 0
0 ffffffffffffffffff 00000000000000000000 ffffffffffffffffff 0 0
0 0123456789abcdef01 00000000000000000000 0123456789abcdef01 0 0
0 a5a5a5a5a5a5a5a5a5 00000000000000000000 a5a5a5a5a5a5a5a5a5 0 0
0 0123456789abcdef01 00000000000000000100 0123456789abcdef01 1 0
0 ffffffffffffffffff 80000000000000000000 ffffffffffffffffff 1 0
0 3c3c3c3c3c3c3c3c3c 00000000080000000000 3c3c3c3c3c3c3c3c3c 1 0
0 5a5a5a5a5a5a5a5a5a 01000000000000000000 5a5a5a5a5a5a5a5a5a 1 0
0 0123456789abcdef01 00000000000000000001 0123456789abcdef01 1 0
0 fedcba9876543210fe 00000000000000000080 fedcba9876543210fe 1 0
0 000000000000000000 00000000000000000008 000000000000000000 1 0
0 00ff00ff00ff00ff00 00000000000000001000 00ff00ff00ff00ff00 1 0
0 123456789abcdef012 00000000000000000000 123456789abcdef012 0 0
0 0123456789abcdef01 00000000000000000300 0123456789abcdef02 0 1
0 ffffffffffffffffff 80000000000000000001 7fffffffffffffffff 0 1
0 a5a5a5a5a5a5a5a5a5 00000000000000000003 a5a5a5a5a5a5a5a5a5 0 1
0 3c3c3c3c3c3c3c3c3c 00000000180000000000 3c3c3c3c243c3c3c3c 0 1
1 0123456789abcdef01 00000000000000000000 0123456789abcdef01 0 0
1 0123456789abcdef01 00000000000000000100 0123456789abcdef00 0 0
1 ffffffffffffffffff 80000000000000000001 7fffffffffffffffff 0 0
1 a5a5a5a5a5a5a5a5a5 00000000000000000002 a5a5a5a5a5a5a5a5a5 0 0
0 a5a5a5a5a5a5a5a5a5 00000000000000000100 a5a5a5a5a5a5a5a5a5 1 0
